/* design/aes_pkg.sv */
//////////////////////////////////////////////////
// AES shared definitions
// Block type seen as bus words or state bytes,
// substitution tables, round constants and the
// control register addresses
//////////////////////////////////////////////////
package aes_pkg;

	// One 128-bit block. words[3] is bus word 0, bytes[15] is AES byte 0
	typedef union packed {
		logic [3:0][31:0] words;
		logic [15:0][7:0] bytes;
	} aes_block_t;

	typedef logic [127:0] aes_round_key_t;

	localparam logic [3:0] addr_start = 4'd14;
	localparam logic [3:0] addr_done  = 4'd15;
	localparam logic [3:0] aes_rounds = 4'd10;

	// Forward S-box, entry 0 first
	localparam logic [0:255][7:0] sbox_table = {
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	// Inverse S-box
	localparam logic [0:255][7:0] inv_sbox_table = {
		128'h52096ad53036a538bf40a39e81f3d7fb,
		128'h7ce339829b2fff87348e4344c4dee9cb,
		128'h547b9432a6c2233dee4c950b42fac34e,
		128'h082ea16628d924b2765ba2496d8bd125,
		128'h72f8f66486689816d4a45ccc5d65b692,
		128'h6c704850fdedb9da5e154657a78d9d84,
		128'h90d8ab008cbcd30af7e45805b8b34506,
		128'hd02c1e8fca3f0f02c1afbd0301138a6b,
		128'h3a9111414f67dcea97f2cfcef0b4e673,
		128'h96ac7422e7ad3585e2f937e81c75df6e,
		128'h47f11a711d29c5896fb7620eaa18be1b,
		128'hfc563e4bc6d279209adbc0fe78cd5af4,
		128'h1fdda8338807c731b11210592780ec5f,
		128'h60517fa919b54a0d2de57a9f93c99cef,
		128'ha0e03b4dae2af5b0c8ebbb3c83539961,
		128'h172b047eba77d626e169146355210c7d
	};

	function automatic logic [7:0] sub_byte(input logic [7:0] b);
		return sbox_table[b];
	endfunction

	function automatic logic [7:0] inv_sub_byte(input logic [7:0] b);
		return inv_sbox_table[b];
	endfunction

	// Round constant, rounds 1 to 10
	function automatic logic [7:0] rcon(input logic [3:0] round);
		case (round)
			4'd1:    return 8'h01;
			4'd2:    return 8'h02;
			4'd3:    return 8'h04;
			4'd4:    return 8'h08;
			4'd5:    return 8'h10;
			4'd6:    return 8'h20;
			4'd7:    return 8'h40;
			4'd8:    return 8'h80;
			4'd9:    return 8'h1b;
			4'd10:   return 8'h36;
			default: return 8'h00;
		endcase
	endfunction

endpackage

/* design/aes_ctrl_if.sv */
//////////////////////////////////////////////////
// Control link between register block and
// decrypt engine
//////////////////////////////////////////////////
`timescale 1ns/100ps

interface aes_ctrl_if;
	import aes_pkg::*;

	aes_block_t key;     // Cipher key from bus words 0-3
	aes_block_t cipher;  // Ciphertext from bus words 4-7
	logic       start;   // One-cycle start strobe
	aes_block_t plain;   // Result, valid with done_pulse
	logic       done_pulse;

	modport regs (
		output key, cipher, start,
		input  plain, done_pulse
	);

	modport engine (
		input  key, cipher, start,
		output plain, done_pulse
	);

endinterface

/* design/avalon_aes_interface.sv */
//////////////////////////////////////////////////
// Memory-mapped register block for the AES
// decrypt engine. 16 words with byte-enable
// merge, registered reads, start strobe and
// the export conduit
//////////////////////////////////////////////////
`timescale 1ns/100ps

module avalon_aes_interface (
	input  logic        CLK,
	input  logic        reset,
	input  logic        avl_read,
	input  logic        avl_write,
	input  logic        avl_cs,
	input  logic [3:0]  avl_byte_en,
	input  logic [3:0]  avl_addr,
	input  logic [31:0] avl_writedata,
	output logic [31:0] avl_readdata,
	output logic [31:0] export_data,
	aes_ctrl_if.regs    ctrl
);
	import aes_pkg::*;

	aes_block_t  key_reg;
	aes_block_t  cipher_reg;
	aes_block_t  plain_reg;     // Loaded by the engine only
	logic [31:0] scratch_reg;   // Shared by words 12 and 13
	logic [31:0] start_reg;
	logic        done_bit;
	logic [31:0] read_reg;
	logic        start_pulse;

	logic        wr_en;
	logic        rd_en;
	logic [1:0]  widx;
	logic [31:0] old_word;
	logic [31:0] merged;
	logic        start_hit;

	assign wr_en = avl_cs && avl_write;
	assign rd_en = avl_cs && avl_read && !avl_write;
	assign widx  = 2'd3 - avl_addr[1:0];   // Lowest address holds the top word

	// Addressed word, shared by the write merge and the read path
	always_comb begin
		if (avl_addr < 4'd4)
			old_word = key_reg.words[widx];
		else if (avl_addr < 4'd8)
			old_word = cipher_reg.words[widx];
		else if (avl_addr < 4'd12)
			old_word = plain_reg.words[widx];
		else if (avl_addr == addr_start)
			old_word = start_reg;
		else if (avl_addr == addr_done)
			old_word = {31'd0, done_bit};
		else
			old_word = scratch_reg;

		// Byte by byte, any enable pattern
		for (int b = 0; b < 4; b++)
			merged[8*b +: 8] = avl_byte_en[b] ? avl_writedata[8*b +: 8] : old_word[8*b +: 8];
	end

	assign start_hit = wr_en && (avl_addr == addr_start) && merged[0];

	always_ff @(posedge CLK) begin
		if (reset) begin
			key_reg     <= '0;
			cipher_reg  <= '0;
			plain_reg   <= '0;
			scratch_reg <= 32'd0;
			start_reg   <= 32'd0;
			done_bit    <= 1'b0;
			read_reg    <= 32'd0;
			start_pulse <= 1'b0;
		end else begin
			start_pulse <= start_hit;

			if (wr_en) begin
				case (avl_addr[3:2])
					2'd0: key_reg.words[widx] <= merged;
					2'd1: cipher_reg.words[widx] <= merged;
					2'd3: begin
						if (avl_addr == addr_start)
							start_reg <= merged;
						else if (avl_addr != addr_done)
							scratch_reg <= merged;
					end
					default: ;   // Plaintext words belong to the engine
				endcase
			end

			if (rd_en)
				read_reg <= old_word;

			if (ctrl.done_pulse)
				plain_reg <= ctrl.plain;

			// A new start wins over a result landing in the same cycle
			if (start_hit)
				done_bit <= 1'b0;
			else if (ctrl.done_pulse)
				done_bit <= 1'b1;
		end
	end

	assign ctrl.key    = key_reg;
	assign ctrl.cipher = cipher_reg;
	assign ctrl.start  = start_pulse;

	assign avl_readdata = read_reg;
	assign export_data  = {cipher_reg.words[3][31:16], cipher_reg.words[0][15:0]};

	// Engine expects isolated strobes
	a_start_single: assert property (@(posedge CLK) disable iff (reset)
		start_pulse |=> !start_pulse);

endmodule

/* design/aes_key_schedule.sv */
//////////////////////////////////////////////////
// AES-128 key expansion
// Derives one round key per cycle and keeps all
// eleven for lookup by round index
//////////////////////////////////////////////////
`timescale 1ns/100ps

module aes_key_schedule (
	input  logic                   CLK,
	input  logic                   reset,
	input  logic                   load,
	input  aes_pkg::aes_block_t    key,
	input  logic [3:0]             index,
	output logic                   ready,
	output aes_pkg::aes_round_key_t round_key
);
	import aes_pkg::*;

	aes_round_key_t keys [0:10];
	aes_round_key_t last_key;   // Most recent key, feeds the next step
	aes_round_key_t src_key;
	aes_round_key_t next_key;
	logic [31:0]    temp;
	logic [7:0]     rc;
	logic [3:0]     count;      // Index of the key being derived
	logic           busy;

	always_comb begin
		src_key = load ? key.words : last_key;
		rc      = rcon(load ? 4'd1 : count);
		// SubWord of RotWord of the last word
		temp = {sub_byte(src_key[23:16]), sub_byte(src_key[15:8]),
			sub_byte(src_key[7:0]), sub_byte(src_key[31:24])} ^ {rc, 24'd0};

		next_key[127:96] = src_key[127:96] ^ temp;
		next_key[95:64]  = src_key[95:64] ^ next_key[127:96];
		next_key[63:32]  = src_key[63:32] ^ next_key[95:64];
		next_key[31:0]   = src_key[31:0] ^ next_key[63:32];
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			busy  <= 1'b0;
			ready <= 1'b0;
			count <= 4'd0;
		end else if (load) begin
			busy  <= 1'b1;
			ready <= 1'b0;
			count <= 4'd2;   // Keys 0 and 1 land on the load edge
		end else if (busy) begin
			count <= count + 4'd1;
			if (count == aes_rounds) begin
				busy  <= 1'b0;
				ready <= 1'b1;
			end
		end
	end

	// Key storage
	always_ff @(posedge CLK) begin
		if (load) begin
			keys[0]  <= key.words;
			keys[1]  <= next_key;
			last_key <= next_key;
		end else if (busy) begin
			keys[count] <= next_key;
			last_key    <= next_key;
		end
	end

	assign round_key = keys[index];

	a_index_range: assert property (@(posedge CLK) disable iff (reset)
		index <= aes_rounds);

endmodule

/* design/aes_inv_round.sv */
//////////////////////////////////////////////////
// One AES inverse round, combinational
// InvShiftRows, InvSubBytes, AddRoundKey and
// optional InvMixColumns
//////////////////////////////////////////////////
`timescale 1ns/100ps

module aes_inv_round (
	input  aes_pkg::aes_block_t     state_in,
	input  aes_pkg::aes_round_key_t round_key,
	input  logic                    mix,
	output aes_pkg::aes_block_t     state_out
);
	import aes_pkg::*;

	aes_block_t shifted;
	aes_block_t added;
	aes_block_t mixed;

	function automatic logic [7:0] xtime(input logic [7:0] a);
		return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
	endfunction

	// GF(2^8) multiply by a 4-bit constant
	function automatic logic [7:0] gmul(input logic [7:0] a, input logic [3:0] m);
		logic [7:0] x2;
		logic [7:0] x4;
		logic [7:0] x8;
		x2 = xtime(a);
		x4 = xtime(x2);
		x8 = xtime(x4);
		return (m[0] ? a : 8'h00) ^ (m[1] ? x2 : 8'h00) ^
			(m[2] ? x4 : 8'h00) ^ (m[3] ? x8 : 8'h00);
	endfunction

	always_comb begin
		// AES byte i sits at bytes[15-i], row i%4, column i/4
		for (int i = 0; i < 16; i++)
			shifted.bytes[15-i] = inv_sub_byte(
				state_in.bytes[15 - ((i % 4) + 4 * (((i / 4) + 4 - (i % 4)) % 4))]);

		added.words = shifted.words ^ round_key;

		for (int c = 0; c < 4; c++) begin
			mixed.bytes[15-4*c] = gmul(added.bytes[15-4*c], 4'd14) ^
				gmul(added.bytes[14-4*c], 4'd11) ^ gmul(added.bytes[13-4*c], 4'd13) ^
				gmul(added.bytes[12-4*c], 4'd9);
			mixed.bytes[14-4*c] = gmul(added.bytes[15-4*c], 4'd9) ^
				gmul(added.bytes[14-4*c], 4'd14) ^ gmul(added.bytes[13-4*c], 4'd11) ^
				gmul(added.bytes[12-4*c], 4'd13);
			mixed.bytes[13-4*c] = gmul(added.bytes[15-4*c], 4'd13) ^
				gmul(added.bytes[14-4*c], 4'd9) ^ gmul(added.bytes[13-4*c], 4'd14) ^
				gmul(added.bytes[12-4*c], 4'd11);
			mixed.bytes[12-4*c] = gmul(added.bytes[15-4*c], 4'd11) ^
				gmul(added.bytes[14-4*c], 4'd13) ^ gmul(added.bytes[13-4*c], 4'd9) ^
				gmul(added.bytes[12-4*c], 4'd14);
		end

		state_out = mix ? mixed : added;   // Last round skips the mix
	end

endmodule

/* design/aes_decrypt_core.sv */
//////////////////////////////////////////////////
// AES-128 decrypt sequencer
// Expands the key, adds round key 10, then runs
// one inverse round per cycle down to round 0
//////////////////////////////////////////////////
`timescale 1ns/100ps

module aes_decrypt_core (
	input  logic        CLK,
	input  logic        reset,
	aes_ctrl_if.engine  ctrl
);
	import aes_pkg::*;

	localparam logic [1:0] st_idle      = 2'd0;
	localparam logic [1:0] st_expand    = 2'd1;
	localparam logic [1:0] st_first_add = 2'd2;
	localparam logic [1:0] st_rounds    = 2'd3;

	logic [1:0]     fsm;
	logic [3:0]     idx;        // Round key index in the rounds state
	aes_block_t     blk;        // Working state
	aes_block_t     round_out;
	aes_round_key_t round_key;
	logic [3:0]     rk_index;
	logic           ks_load;
	logic           ks_ready;

	assign ks_load  = (fsm == st_idle) && ctrl.start;   // Busy engine drops start
	assign rk_index = (fsm == st_rounds) ? idx : aes_rounds;

	aes_key_schedule u_key_schedule (
		.CLK       (CLK),
		.reset     (reset),
		.load      (ks_load),
		.key       (ctrl.key),
		.index     (rk_index),
		.ready     (ks_ready),
		.round_key (round_key)
	);

	aes_inv_round u_inv_round (
		.state_in  (blk),
		.round_key (round_key),
		.mix       (idx != 4'd0),
		.state_out (round_out)
	);

	always_ff @(posedge CLK) begin
		if (reset) begin
			fsm <= st_idle;
			idx <= 4'd0;
		end else begin
			case (fsm)
				st_idle:      if (ctrl.start) fsm <= st_expand;
				st_expand:    if (ks_ready) fsm <= st_first_add;
				st_first_add: begin
					fsm <= st_rounds;
					idx <= aes_rounds - 4'd1;
				end
				st_rounds: begin
					if (idx == 4'd0)
						fsm <= st_idle;
					else
						idx <= idx - 4'd1;
				end
			endcase
		end
	end

	// Data path
	always_ff @(posedge CLK) begin
		if (ks_load)
			blk <= ctrl.cipher;
		else if (fsm == st_first_add)
			blk.words <= blk.words ^ round_key;
		else if (fsm == st_rounds)
			blk <= round_out;
	end

	// Last round result goes straight out
	assign ctrl.plain      = round_out;
	assign ctrl.done_pulse = (fsm == st_rounds) && (idx == 4'd0);

	// Result only from a complete key schedule
	a_done_keys: assert property (@(posedge CLK) disable iff (reset)
		ctrl.done_pulse |-> ks_ready);

	// 10 expand + 1 first add + 10 rounds
	a_latency: assert property (@(posedge CLK) disable iff (reset)
		(fsm == st_idle && ctrl.start) |-> ##21 ctrl.done_pulse);

endmodule

/* design/aes_top.sv */
//////////////////////////////////////////////////
// AES decrypt peripheral top level
// Register block and decrypt engine on one link
//////////////////////////////////////////////////
`timescale 1ns/100ps

module aes_top (
	input  logic        CLK,
	input  logic        reset,
	input  logic        avl_read,
	input  logic        avl_write,
	input  logic        avl_cs,
	input  logic [3:0]  avl_byte_en,
	input  logic [3:0]  avl_addr,
	input  logic [31:0] avl_writedata,
	output logic [31:0] avl_readdata,
	output logic [31:0] export_data
);

	aes_ctrl_if ctrl ();

	avalon_aes_interface u_regs (
		.CLK           (CLK),
		.reset         (reset),
		.avl_read      (avl_read),
		.avl_write     (avl_write),
		.avl_cs        (avl_cs),
		.avl_byte_en   (avl_byte_en),
		.avl_addr      (avl_addr),
		.avl_writedata (avl_writedata),
		.avl_readdata  (avl_readdata),
		.export_data   (export_data),
		.ctrl          (ctrl)
	);

	aes_decrypt_core u_core (
		.CLK   (CLK),
		.reset (reset),
		.ctrl  (ctrl)
	);

endmodule

/* tests/aes_tb.sv */
//////////////////////////////////////////////////
// Testbench for the AES decrypt peripheral
// Bus register checks, byte-enable merge, two
// known decrypt vectors and the export conduit
//////////////////////////////////////////////////
`timescale 1ns/100ps

module aes_tb;

	localparam int expected_cycles = 600;
	localparam int timeout_cycles  = 5 * expected_cycles;
	localparam int max_polls       = 100;

	logic        CLK;
	logic        reset;
	logic        avl_read;
	logic        avl_write;
	logic        avl_cs;
	logic [3:0]  avl_byte_en;
	logic [3:0]  avl_addr;
	logic [31:0] avl_writedata;
	logic [31:0] avl_readdata;
	logic [31:0] export_data;

	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	logic [15:0] lfsr;
	logic [31:0] model [0:15];   // Expected read value of each word
	logic [3:0]  rw_addrs [0:9] = '{4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7,
		4'd12, 4'd14};

	aes_top dut (
		.CLK           (CLK),
		.reset         (reset),
		.avl_read      (avl_read),
		.avl_write     (avl_write),
		.avl_cs        (avl_cs),
		.avl_byte_en   (avl_byte_en),
		.avl_addr      (avl_addr),
		.avl_writedata (avl_writedata),
		.avl_readdata  (avl_readdata),
		.export_data   (export_data)
	);

	always #2 CLK = ~CLK;

	always @(posedge CLK) cycles <= cycles + 1;

	initial begin
		wait (cycles >= timeout_cycles);
		$display("Timeout: run did not finish within %0d cycles", timeout_cycles);
		$display("CHECKS FAILED");
		$finish;
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	// One LFSR step per bit
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = 32'd0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old,
		input logic [31:0] data, input logic [3:0] be);
		logic [31:0] m;
		for (int b = 0; b < 4; b++)
			m[8*b +: 8] = be[b] ? data[8*b +: 8] : old[8*b +: 8];
		return m;
	endfunction

	task automatic check_equal(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("Fail %s: got 0x%08h expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic bus_write(input logic [3:0] addr, input logic [31:0] data,
		input logic [3:0] be);
		logic [31:0] merged;
		merged        = merge_bytes(model[addr], data, be);
		avl_cs        = 1'b1;
		avl_write     = 1'b1;
		avl_addr      = addr;
		avl_writedata = data;
		avl_byte_en   = be;
		@(negedge CLK);
		avl_cs      = 1'b0;
		avl_write   = 1'b0;
		avl_byte_en = 4'd0;
		if ((addr >= 4'd8 && addr <= 4'd11) || addr == 4'd15)
			;   // Engine-owned, bus write has no effect
		else if (addr == 4'd12 || addr == 4'd13) begin
			model[12] = merged;
			model[13] = merged;
		end else begin
			model[addr] = merged;
			if (addr == 4'd14 && merged[0])
				model[15] = 32'd0;   // Start clears done
		end
	endtask

	task automatic bus_read(input logic [3:0] addr, output logic [31:0] data);
		avl_cs   = 1'b1;
		avl_read = 1'b1;
		avl_addr = addr;
		@(negedge CLK);
		avl_cs   = 1'b0;
		avl_read = 1'b0;
		data     = avl_readdata;   // Registered on the edge just passed
	endtask

	task automatic check_word(input logic [3:0] addr);
		logic [31:0] got;
		bus_read(addr, got);
		check_equal($sformatf("avl_readdata word %0d", addr), got, model[addr]);
	endtask

	task automatic check_export();
		check_equal("export_data", export_data, {model[4][31:16], model[7][15:0]});
	endtask

	task automatic run_vector(input logic [127:0] key, input logic [127:0] cipher,
		input logic [127:0] plain);
		logic [31:0] got;
		int          polls;
		for (int i = 0; i < 4; i++)
			bus_write(4'(i), key[127-32*i -: 32], 4'hf);
		for (int i = 0; i < 4; i++)
			bus_write(4'(4 + i), cipher[127-32*i -: 32], 4'hf);
		check_export();
		bus_write(4'd14, 32'd1, 4'hf);
		check_word(4'd15);   // Done cleared by the start
		polls = 0;
		got   = 32'd0;
		while (!got[0] && polls < max_polls) begin
			bus_read(4'd15, got);
			polls++;
		end
		checks++;
		assert (got[0])
		else begin
			errors++;
			$display("Done bit still clear after %0d polls", polls);
		end
		if (got[0]) begin
			model[15] = 32'd1;
			for (int i = 0; i < 4; i++)
				model[8 + i] = plain[127-32*i -: 32];
			for (int i = 0; i < 4; i++)
				check_word(4'(8 + i));
		end
	endtask

	initial begin
		logic [31:0] data;
		logic [3:0]  addr;
		logic [3:0]  be;
		CLK           = 1'b0;
		reset         = 1'b1;
		avl_read      = 1'b0;
		avl_write     = 1'b0;
		avl_cs        = 1'b0;
		avl_byte_en   = 4'd0;
		avl_addr      = 4'd0;
		avl_writedata = 32'd0;
		lfsr          = 16'd53211;
		for (int i = 0; i < 16; i++)
			model[i] = 32'd0;
		repeat (10) @(negedge CLK);
		reset = 1'b0;

		// Everything reads zero out of reset
		check_export();
		for (int a = 0; a < 16; a++)
			check_word(4'(a));

		// Full-word writes
		for (int pass = 0; pass < 3; pass++) begin
			for (int i = 0; i < 10; i++) begin
				data = random_bits(32);
				if (rw_addrs[i] == 4'd14)
					data[0] = 1'b0;   // Keep the engine idle
				bus_write(rw_addrs[i], data, 4'hf);
				check_word(rw_addrs[i]);
				check_export();
			end
		end
		check_word(4'd12);
		check_word(4'd13);

		// Byte-enable merge
		repeat (40) begin
			addr = rw_addrs[random_bits(4) % 10];
			be   = random_bits(4);
			data = random_bits(32);
			if (addr == 4'd14)
				data[0] = 1'b0;
			bus_write(addr, data, be);
			check_word(addr);
			check_export();
		end

		run_vector(128'h000102030405060708090a0b0c0d0e0f,
			128'h69c4e0d86a7b0430d8cdb78070b4c55a,
			128'h00112233445566778899aabbccddeeff);
		run_vector(128'h2b7e151628aed2a6abf7158809cf4f3c,
			128'h3925841d02dc09fbdc118597196a0b32,
			128'h3243f6a8885a308d313198a2e0370734);

		// Bus writes to engine-owned words
		for (int i = 0; i < 5; i++) begin
			addr = (i == 4) ? 4'd15 : 4'(8 + i);
			bus_write(addr, random_bits(32), 4'hf);
			check_word(addr);
			bus_write(addr, random_bits(32), random_bits(4));
			check_word(addr);
		end
		check_export();

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* sim.f */
design/aes_pkg.sv
design/aes_ctrl_if.sv
design/avalon_aes_interface.sv
design/aes_key_schedule.sv
design/aes_inv_round.sv
design/aes_decrypt_core.sv
design/aes_top.sv
tests/aes_tb.sv
